// File: rtl/ex_pkg.sv
/*
 * Shared encodings for the execute stage.
 * Condition codes use the LEGv8 B.cond numbering. Only EQ, NE, LT, GE, MI
 * and AL are decoded, and any other code is never taken.
 * Unused ALU op codes fall back to passing operand B.
 */
package ex_pkg;

	// alu control field, 3 bits as driven by decode
	typedef enum logic [2:0] {
		ALU_PASS_B = 3'b000,
		ALU_ADD    = 3'b010,
		// a minus b
		ALU_SUB    = 3'b011,
		ALU_AND    = 3'b100,
		ALU_OR     = 3'b101,
		ALU_XOR    = 3'b110
	} alu_op_t;

	// kind of control transfer carried by the instruction
	typedef enum logic [2:0] {
		BR_NONE   = 3'd0,
		BR_UNCOND = 3'd1,
		// taken when the store-data register reads zero
		BR_CBZ    = 3'd2,
		BR_CBNZ   = 3'd3,
		// taken by the condition code against the flag register
		BR_COND   = 3'd4
	} br_kind_t;

	// condition field of B.cond
	typedef enum logic [3:0] {
		COND_EQ = 4'b0000,
		COND_NE = 4'b0001,
		COND_MI = 4'b0100,
		COND_GE = 4'b1010,
		COND_LT = 4'b1011,
		COND_AL = 4'b1110
	} cond_t;

endpackage

// File: rtl/ex_operand_stage.sv
/*
 * ID/EX pipeline register with the operand B select.
 * Fields are captured only on issue. op_valid is a one-cycle marker and
 * drops on any cycle without issue; payload fields keep stale values then.
 * No stall input, the stage loads every issued instruction.
 */
`timescale 1ns/1ps

module ex_operand_stage import ex_pkg::*; #(
	parameter int DATA_WIDTH = 64
) (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  issue,
	input  logic [DATA_WIDTH-1:0] read_data1,
	input  logic [DATA_WIDTH-1:0] read_data2,
	input  logic [DATA_WIDTH-1:0] imm,
	input  logic [DATA_WIDTH-1:0] pc,
	input  logic [DATA_WIDTH-1:0] br_offset,
	input  alu_op_t               alu_op,
	input  logic                  alu_src,
	input  logic                  set_flags,
	input  br_kind_t              br_kind,
	input  cond_t                 cond,
	output logic                  op_valid,
	output logic [DATA_WIDTH-1:0] operand_a,
	output logic [DATA_WIDTH-1:0] operand_b,
	output logic [DATA_WIDTH-1:0] store_operand,
	output logic [DATA_WIDTH-1:0] pc_q,
	output logic [DATA_WIDTH-1:0] br_offset_q,
	output alu_op_t               alu_op_q,
	output logic                  set_flags_q,
	output br_kind_t              br_kind_q,
	output cond_t                 cond_q
);

	// valid marker, the only control state here
	always_ff @(posedge clk) begin
		if (reset)
			op_valid <= 1'b0;
		else
			op_valid <= issue;
	end

	// payload, loaded on issue and held otherwise
	always_ff @(posedge clk) begin
		if (issue) begin
			operand_a     <= read_data1;
			// immediate or data-transfer offset replaces rm
			operand_b     <= alu_src ? imm : read_data2;
			// rt for stores and cbz/cbnz, independent of alu_src
			store_operand <= read_data2;
			pc_q          <= pc;
			br_offset_q   <= br_offset;
			alu_op_q      <= alu_op;
			set_flags_q   <= set_flags;
			br_kind_q     <= br_kind;
			cond_q        <= cond;
		end
	end

endmodule

// File: rtl/ex_alu.sv
/*
 * Combinational ALU for the execute stage.
 * Carry and overflow are only meaningful for add and subtract and read 0
 * for every other op. Subtract carry follows the ARM convention: the
 * carry out of a + ~b + 1, so carry set means no borrow.
 */
`timescale 1ns/1ps

module ex_alu import ex_pkg::*; #(
	parameter int DATA_WIDTH = 64
) (
	input  logic [DATA_WIDTH-1:0] a,
	input  logic [DATA_WIDTH-1:0] b,
	input  alu_op_t               op,
	output logic [DATA_WIDTH-1:0] result,
	output logic                  negative,
	output logic                  zero,
	output logic                  overflow,
	output logic                  carry_out
);

	localparam int MSB = DATA_WIDTH - 1;

	// one adder serves both add and subtract
	logic                  is_sub;
	logic [DATA_WIDTH-1:0] b_adj;
	logic [DATA_WIDTH:0]   sum_ext;
	logic [DATA_WIDTH-1:0] sum;
	logic                  sum_carry;
	logic                  sum_ovf;

	assign is_sub = (op == ALU_SUB);

	// invert b and inject the +1 through the carry-in for subtract
	assign b_adj   = is_sub ? ~b : b;
	assign sum_ext = {1'b0, a} + {1'b0, b_adj} + {{DATA_WIDTH{1'b0}}, is_sub};
	assign sum       = sum_ext[MSB:0];
	assign sum_carry = sum_ext[DATA_WIDTH];

	// signed overflow: operands agree in sign, sum does not
	assign sum_ovf = (a[MSB] == b_adj[MSB]) && (sum[MSB] != a[MSB]);

	always_comb begin
		result    = b;
		carry_out = 1'b0;
		overflow  = 1'b0;
		case (op)
			ALU_ADD,
			ALU_SUB: begin
				result    = sum;
				carry_out = sum_carry;
				overflow  = sum_ovf;
			end
			ALU_AND: begin
				result = a & b;
			end
			ALU_OR: begin
				result = a | b;
			end
			ALU_XOR: begin
				result = a ^ b;
			end
			// pass b, also covers the unused codes
			default: begin
				result = b;
			end
		endcase
	end

	// n and z come straight from the result for every op
	assign negative = result[MSB];
	assign zero     = (result == '0);

endmodule

// File: rtl/ex_branch_unit.sv
/*
 * Branch target adder and taken decision.
 * br_offset is a word offset, already sign-extended by decode; the target
 * wraps at DATA_WIDTH bits. B.cond reads the flag register, so a flag
 * setter issued one cycle earlier is visible here.
 */
`timescale 1ns/1ps

module ex_branch_unit import ex_pkg::*; #(
	parameter int DATA_WIDTH = 64
) (
	input  logic [DATA_WIDTH-1:0] pc,
	input  logic [DATA_WIDTH-1:0] br_offset,
	input  logic [DATA_WIDTH-1:0] store_operand,
	input  br_kind_t              kind,
	input  cond_t                 cond,
	input  logic                  negative,
	input  logic                  zero,
	input  logic                  overflow,
	output logic [DATA_WIDTH-1:0] target,
	output logic                  taken
);

	logic [DATA_WIDTH-1:0] byte_offset;
	logic                  rt_zero;
	logic                  cond_true;

	// words to bytes, top two bits of the offset fall off
	assign byte_offset = {br_offset[DATA_WIDTH-3:0], 2'b00};
	assign target      = pc + byte_offset;

	// cbz / cbnz test the register, not the flags
	assign rt_zero = (store_operand == '0);

	// condition code against the stored flags
	always_comb begin
		case (cond)
			COND_EQ: cond_true = zero;
			COND_NE: cond_true = ~zero;
			// signed less-than
			COND_LT: cond_true = (negative != overflow);
			COND_GE: cond_true = (negative == overflow);
			COND_MI: cond_true = negative;
			COND_AL: cond_true = 1'b1;
			// undecoded codes never branch
			default: cond_true = 1'b0;
		endcase
	end

	always_comb begin
		case (kind)
			BR_UNCOND: begin
				taken = 1'b1;
			end
			BR_CBZ: begin
				taken = rt_zero;
			end
			BR_CBNZ: begin
				taken = ~rt_zero;
			end
			BR_COND: begin
				taken = cond_true;
			end
			// BR_NONE and spare kinds
			default: begin
				taken = 1'b0;
			end
		endcase
	end

endmodule

// File: rtl/ex_result_stage.sv
/*
 * EX/MEM register and the NZVC flag register.
 * alu_flags_in is packed as {negative, zero, overflow, carry}.
 * Data outputs load on every valid op and hold between ops. br_taken and
 * result_valid are pulses. Flags load only for flag-setting ops.
 */
`timescale 1ns/1ps

module ex_result_stage #(
	parameter int DATA_WIDTH = 64
) (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  op_valid,
	input  logic                  set_flags,
	input  logic [DATA_WIDTH-1:0] alu_result_in,
	input  logic [3:0]            alu_flags_in,
	input  logic [DATA_WIDTH-1:0] store_operand,
	input  logic [DATA_WIDTH-1:0] target_in,
	input  logic                  taken_in,
	output logic                  result_valid,
	output logic [DATA_WIDTH-1:0] alu_result,
	output logic [DATA_WIDTH-1:0] store_data,
	output logic [DATA_WIDTH-1:0] br_target,
	output logic                  br_taken,
	output logic                  negative,
	output logic                  zero,
	output logic                  overflow,
	output logic                  carry_out
);

	// strobes, both follow op_valid by one edge
	always_ff @(posedge clk) begin
		if (reset) begin
			result_valid <= 1'b0;
			br_taken     <= 1'b0;
		end else begin
			result_valid <= op_valid;
			// a bubble must not look like a taken branch
			br_taken     <= op_valid & taken_in;
		end
	end

	// payload for the memory stage
	always_ff @(posedge clk) begin
		if (op_valid) begin
			alu_result <= alu_result_in;
			store_data <= store_operand;
			br_target  <= target_in;
		end
	end

	// flag register, also feeds B.cond of the next op
	always_ff @(posedge clk) begin
		if (reset) begin
			negative  <= 1'b0;
			zero      <= 1'b0;
			overflow  <= 1'b0;
			carry_out <= 1'b0;
		end else if (op_valid && set_flags) begin
			negative  <= alu_flags_in[3];
			zero      <= alu_flags_in[2];
			overflow  <= alu_flags_in[1];
			carry_out <= alu_flags_in[0];
		end
	end

endmodule

// File: rtl/ex_top.sv
/*
 * Execute stage top. Inputs are sampled on issue; results appear with
 * result_valid two edges later. No stall or forwarding, the caller must
 * present operands already resolved.
 */
`timescale 1ns/1ps

module ex_top import ex_pkg::*; #(
	parameter int DATA_WIDTH = 64
) (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  issue,
	input  logic [DATA_WIDTH-1:0] read_data1,
	input  logic [DATA_WIDTH-1:0] read_data2,
	input  logic [DATA_WIDTH-1:0] pc,
	input  logic [DATA_WIDTH-1:0] imm,
	input  logic [DATA_WIDTH-1:0] br_offset,
	input  alu_op_t               alu_op,
	input  logic                  alu_src,
	input  logic                  set_flags,
	input  br_kind_t              br_kind,
	input  cond_t                 cond,
	output logic                  result_valid,
	output logic [DATA_WIDTH-1:0] alu_result,
	output logic [DATA_WIDTH-1:0] store_data,
	output logic [DATA_WIDTH-1:0] br_target,
	output logic                  br_taken,
	output logic                  negative,
	output logic                  zero,
	output logic                  overflow,
	output logic                  carry_out
);

	// operand stage to processing
	logic                  op_valid;
	logic [DATA_WIDTH-1:0] operand_a;
	logic [DATA_WIDTH-1:0] operand_b;
	logic [DATA_WIDTH-1:0] store_operand;
	logic [DATA_WIDTH-1:0] pc_q;
	logic [DATA_WIDTH-1:0] br_offset_q;
	alu_op_t               alu_op_q;
	logic                  set_flags_q;
	br_kind_t              br_kind_q;
	cond_t                 cond_q;

	// processing to result stage
	logic [DATA_WIDTH-1:0] alu_out;
	logic                  alu_n;
	logic                  alu_z;
	logic                  alu_v;
	logic                  alu_c;
	logic [DATA_WIDTH-1:0] target;
	logic                  taken;

	ex_operand_stage #(.DATA_WIDTH(DATA_WIDTH)) u_operand (
		.clk(clk), .reset(reset), .issue(issue),
		.read_data1(read_data1), .read_data2(read_data2), .imm(imm),
		.pc(pc), .br_offset(br_offset), .alu_op(alu_op), .alu_src(alu_src),
		.set_flags(set_flags), .br_kind(br_kind), .cond(cond),
		.op_valid(op_valid), .operand_a(operand_a), .operand_b(operand_b),
		.store_operand(store_operand), .pc_q(pc_q), .br_offset_q(br_offset_q),
		.alu_op_q(alu_op_q), .set_flags_q(set_flags_q), .br_kind_q(br_kind_q),
		.cond_q(cond_q)
	);

	ex_alu #(.DATA_WIDTH(DATA_WIDTH)) u_alu (
		.a(operand_a), .b(operand_b), .op(alu_op_q), .result(alu_out),
		.negative(alu_n), .zero(alu_z), .overflow(alu_v), .carry_out(alu_c)
	);

	// branch decision uses the registered flags, not the raw ALU ones
	ex_branch_unit #(.DATA_WIDTH(DATA_WIDTH)) u_branch (
		.pc(pc_q), .br_offset(br_offset_q), .store_operand(store_operand),
		.kind(br_kind_q), .cond(cond_q), .negative(negative), .zero(zero),
		.overflow(overflow), .target(target), .taken(taken)
	);

	ex_result_stage #(.DATA_WIDTH(DATA_WIDTH)) u_result (
		.clk(clk), .reset(reset), .op_valid(op_valid), .set_flags(set_flags_q),
		.alu_result_in(alu_out), .alu_flags_in({alu_n, alu_z, alu_v, alu_c}),
		.store_operand(store_operand), .target_in(target), .taken_in(taken),
		.result_valid(result_valid), .alu_result(alu_result),
		.store_data(store_data), .br_target(br_target), .br_taken(br_taken),
		.negative(negative), .zero(zero), .overflow(overflow),
		.carry_out(carry_out)
	);

endmodule

// File: tests/ex_tb_vectors.svh
/*
 * Stimulus table for ex_tb, worked out by hand from the ALU, flag and
 * branch rules. The columns are name, rd1, rd2, imm, alu_src, alu_op,
 * set_flags, pc, br_offset, br_kind, cond, expected result, store data,
 * target, taken and flags as {n, z, v, c}. Gap rows issue nothing.
 */

task automatic load_table();
	// flags read 0000 after reset
	add_row("add_reg", 64'h5, 64'h7, 64'h100, 1'b0, ALU_ADD, 1'b0,
		64'h1000, 64'h0, BR_NONE, COND_EQ, 64'hc, 64'h7, 64'h1000, 1'b0, 4'b0000);
	add_row("add_imm", 64'h5, 64'h7, 64'h100, 1'b1, ALU_ADD, 1'b0,
		64'h1000, 64'h0, BR_NONE, COND_EQ, 64'h105, 64'h7, 64'h1000, 1'b0, 4'b0000);
	add_row("adds_carry", 64'hffffffffffffffff, 64'h1, 64'h0, 1'b0, ALU_ADD, 1'b1,
		64'h1000, 64'h0, BR_NONE, COND_EQ, 64'h0, 64'h1, 64'h1000, 1'b0, 4'b0101);
	// back to back with the flag setter above
	add_row("beq_taken", 64'h0, 64'h0, 64'h0, 1'b0, ALU_PASS_B, 1'b0,
		64'h2000, 64'h4, BR_COND, COND_EQ, 64'h0, 64'h0, 64'h2010, 1'b1, 4'b0101);
	add_row("adds_ovf", 64'h7fffffffffffffff, 64'h1, 64'h0, 1'b0, ALU_ADD, 1'b1,
		64'h1000, 64'h0, BR_NONE, COND_EQ, 64'h8000000000000000, 64'h1, 64'h1000, 1'b0, 4'b1010);
	// n equals v here with a negative offset
	add_row("blt_not_taken", 64'h0, 64'h9, 64'h42, 1'b1, ALU_PASS_B, 1'b0,
		64'h3000, 64'hffffffffffffffff, BR_COND, COND_LT, 64'h42, 64'h9, 64'h2ffc, 1'b0, 4'b1010);
	add_row("subs_zero", 64'h55, 64'h55, 64'h0, 1'b0, ALU_SUB, 1'b1,
		64'h1000, 64'h0, BR_NONE, COND_EQ, 64'h0, 64'h55, 64'h1000, 1'b0, 4'b0101);
	add_row("bne_not_taken", 64'h0, 64'h0, 64'h0, 1'b0, ALU_PASS_B, 1'b0,
		64'h5000, 64'h1, BR_COND, COND_NE, 64'h0, 64'h0, 64'h5004, 1'b0, 4'b0101);
	// 3 - 5 borrows so carry stays clear
	add_row("subs_neg", 64'h3, 64'h5, 64'h0, 1'b0, ALU_SUB, 1'b1,
		64'h1000, 64'h0, BR_NONE, COND_EQ, 64'hfffffffffffffffe, 64'h5, 64'h1000, 1'b0, 4'b1000);
	add_row("blt_taken", 64'h0, 64'h0, 64'h0, 1'b0, ALU_PASS_B, 1'b0,
		64'h6000, 64'h3, BR_COND, COND_LT, 64'h0, 64'h0, 64'h600c, 1'b1, 4'b1000);
	add_row("and_imm", 64'hf0f0, 64'h1234, 64'hff0, 1'b1, ALU_AND, 1'b0,
		64'h1000, 64'h0, BR_NONE, COND_EQ, 64'hf0, 64'h1234, 64'h1000, 1'b0, 4'b1000);
	// flags from subs_neg survive the non-setting and
	add_row("bmi_held_flags", 64'h0, 64'h0, 64'h0, 1'b0, ALU_PASS_B, 1'b0,
		64'h7000, 64'h0, BR_COND, COND_MI, 64'h0, 64'h0, 64'h7000, 1'b1, 4'b1000);
	add_gap("gap_a");
	add_gap("gap_b");
	add_row("orr_imm", 64'ha000, 64'h77, 64'hb0, 1'b1, ALU_OR, 1'b0,
		64'h1000, 64'h0, BR_NONE, COND_EQ, 64'ha0b0, 64'h77, 64'h1000, 1'b0, 4'b1000);
	add_row("orr_reg", 64'h1, 64'h2, 64'h0, 1'b0, ALU_OR, 1'b0,
		64'h1000, 64'h0, BR_NONE, COND_EQ, 64'h3, 64'h2, 64'h1000, 1'b0, 4'b1000);
	add_row("eor_reg", 64'hff00, 64'hff0, 64'h0, 1'b0, ALU_XOR, 1'b0,
		64'h1000, 64'h0, BR_NONE, COND_EQ, 64'hf0f0, 64'hff0, 64'h1000, 1'b0, 4'b1000);
	add_row("eor_imm", 64'hff, 64'h3, 64'hf, 1'b1, ALU_XOR, 1'b0,
		64'h1000, 64'h0, BR_NONE, COND_EQ, 64'hf0, 64'h3, 64'h1000, 1'b0, 4'b1000);
	add_row("ands_zero", 64'hf0, 64'hf, 64'h0, 1'b0, ALU_AND, 1'b1,
		64'h1000, 64'h0, BR_NONE, COND_EQ, 64'h0, 64'hf, 64'h1000, 1'b0, 4'b0100);
	add_row("beq_after_ands", 64'h0, 64'h0, 64'h0, 1'b0, ALU_PASS_B, 1'b0,
		64'h8000, 64'h0, BR_COND, COND_EQ, 64'h0, 64'h0, 64'h8000, 1'b1, 4'b0100);
	// cbz and cbnz look at rd2 instead of the flags
	add_row("cbz_taken", 64'h0, 64'h0, 64'h0, 1'b0, ALU_PASS_B, 1'b0,
		64'h9000, 64'h8, BR_CBZ, COND_EQ, 64'h0, 64'h0, 64'h9020, 1'b1, 4'b0100);
	add_row("cbz_not_taken", 64'h0, 64'h10, 64'h0, 1'b0, ALU_PASS_B, 1'b0,
		64'h9000, 64'h8, BR_CBZ, COND_EQ, 64'h10, 64'h10, 64'h9020, 1'b0, 4'b0100);
	add_row("cbnz_taken", 64'h0, 64'h10, 64'h0, 1'b0, ALU_PASS_B, 1'b0,
		64'h9000, 64'h8, BR_CBNZ, COND_EQ, 64'h10, 64'h10, 64'h9020, 1'b1, 4'b0100);
	add_row("cbnz_not_taken", 64'h0, 64'h0, 64'h0, 1'b0, ALU_PASS_B, 1'b0,
		64'h9000, 64'h8, BR_CBNZ, COND_EQ, 64'h0, 64'h0, 64'h9020, 1'b0, 4'b0100);
	add_row("b_uncond", 64'h0, 64'h0, 64'h0, 1'b0, ALU_PASS_B, 1'b0,
		64'ha000, 64'hffffffffffffff00, BR_UNCOND, COND_EQ, 64'h0, 64'h0, 64'h9c00, 1'b1, 4'b0100);
	add_row("bal_taken", 64'h0, 64'h0, 64'h0, 1'b0, ALU_PASS_B, 1'b0,
		64'h0, 64'h1, BR_COND, COND_AL, 64'h0, 64'h0, 64'h4, 1'b1, 4'b0100);
	add_row("subs_imm", 64'h100, 64'h5, 64'h1, 1'b1, ALU_SUB, 1'b1,
		64'h1000, 64'h0, BR_NONE, COND_EQ, 64'hff, 64'h5, 64'h1000, 1'b0, 4'b0001);
	add_row("bge_taken", 64'h0, 64'h0, 64'h0, 1'b0, ALU_PASS_B, 1'b0,
		64'h200, 64'h0, BR_COND, COND_GE, 64'h0, 64'h0, 64'h200, 1'b1, 4'b0001);
	// most negative minus one wraps positive
	add_row("subs_ovf", 64'h8000000000000000, 64'h1, 64'h0, 1'b0, ALU_SUB, 1'b1,
		64'h1000, 64'h0, BR_NONE, COND_EQ, 64'h7fffffffffffffff, 64'h1, 64'h1000, 1'b0, 4'b0011);
	add_row("blt_ovf", 64'h0, 64'h0, 64'h0, 1'b0, ALU_PASS_B, 1'b0,
		64'h300, 64'h0, BR_COND, COND_LT, 64'h0, 64'h0, 64'h300, 1'b1, 4'b0011);
	// the other outcome of each condition under flags 0011
	add_row("beq_not_taken", 64'h0, 64'h0, 64'h0, 1'b0, ALU_PASS_B, 1'b0,
		64'h400, 64'h0, BR_COND, COND_EQ, 64'h0, 64'h0, 64'h400, 1'b0, 4'b0011);
	add_row("bne_taken", 64'h0, 64'h0, 64'h0, 1'b0, ALU_PASS_B, 1'b0,
		64'h500, 64'h0, BR_COND, COND_NE, 64'h0, 64'h0, 64'h500, 1'b1, 4'b0011);
	add_row("bmi_not_taken", 64'h0, 64'h0, 64'h0, 1'b0, ALU_PASS_B, 1'b0,
		64'h600, 64'h0, BR_COND, COND_MI, 64'h0, 64'h0, 64'h600, 1'b0, 4'b0011);
	add_row("bge_not_taken", 64'h0, 64'h0, 64'h0, 1'b0, ALU_PASS_B, 1'b0,
		64'h700, 64'h0, BR_COND, COND_GE, 64'h0, 64'h0, 64'h700, 1'b0, 4'b0011);
	// an undecoded code never branches although c is set
	add_row("bcond_undecoded", 64'h0, 64'h0, 64'h0, 1'b0, ALU_PASS_B, 1'b0,
		64'h800, 64'h0, BR_COND, cond_t'(4'b0010), 64'h0, 64'h0, 64'h800, 1'b0, 4'b0011);
	// a spare op code passes b and clears c and v
	add_row("spare_op_pass_b", 64'h5, 64'h9, 64'h0, 1'b0, alu_op_t'(3'b111), 1'b1,
		64'h1000, 64'h0, BR_NONE, COND_EQ, 64'h9, 64'h9, 64'h1000, 1'b0, 4'b0000);
endtask

// File: tests/ex_tb.sv
/*
 * Testbench for ex_top at the default 64-bit width.
 * One table row is driven per clock. Each result_valid is matched to the
 * oldest issued row still outstanding. Stops at the first mismatch.
 */
`timescale 1ns/1ps

module ex_tb import ex_pkg::*; ();

	localparam int DATA_WIDTH   = 64;
	localparam int RESET_CYCLES = 16;
	localparam int MAX_ROWS     = 40;

	logic                  clk = 1'b0;
	logic                  reset;
	logic                  issue;
	logic [DATA_WIDTH-1:0] read_data1;
	logic [DATA_WIDTH-1:0] read_data2;
	logic [DATA_WIDTH-1:0] pc;
	logic [DATA_WIDTH-1:0] imm;
	logic [DATA_WIDTH-1:0] br_offset;
	alu_op_t               alu_op;
	logic                  alu_src;
	logic                  set_flags;
	br_kind_t              br_kind;
	cond_t                 cond;
	logic                  result_valid;
	logic [DATA_WIDTH-1:0] alu_result;
	logic [DATA_WIDTH-1:0] store_data;
	logic [DATA_WIDTH-1:0] br_target;
	logic                  br_taken;
	logic                  negative;
	logic                  zero;
	logic                  overflow;
	logic                  carry_out;
	logic [3:0]            nzvc;

	// t_ columns hold stimulus and x_ columns the expected values
	string                 t_name[MAX_ROWS];
	logic                  t_issue[MAX_ROWS];
	logic [DATA_WIDTH-1:0] t_rd1[MAX_ROWS];
	logic [DATA_WIDTH-1:0] t_rd2[MAX_ROWS];
	logic [DATA_WIDTH-1:0] t_imm[MAX_ROWS];
	logic                  t_src[MAX_ROWS];
	alu_op_t               t_op[MAX_ROWS];
	logic                  t_sf[MAX_ROWS];
	logic [DATA_WIDTH-1:0] t_pc[MAX_ROWS];
	logic [DATA_WIDTH-1:0] t_off[MAX_ROWS];
	br_kind_t              t_kind[MAX_ROWS];
	cond_t                 t_cond[MAX_ROWS];
	logic [DATA_WIDTH-1:0] x_res[MAX_ROWS];
	logic [DATA_WIDTH-1:0] x_store[MAX_ROWS];
	logic [DATA_WIDTH-1:0] x_target[MAX_ROWS];
	logic                  x_taken[MAX_ROWS];
	logic [3:0]            x_nzvc[MAX_ROWS];
	int                    n_rows = 0;

	// issued rows not yet retired with the oldest first
	int                    pending[$];
	int                    cycles = 0;
	int                    limit;
	logic                  seen_result = 1'b0;
	logic [DATA_WIDTH-1:0] last_res;
	logic [DATA_WIDTH-1:0] last_store;
	logic [DATA_WIDTH-1:0] last_target;
	logic [3:0]            last_nzvc = 4'b0000;

	ex_top #(.DATA_WIDTH(DATA_WIDTH)) UUT (.*);

	assign nzvc = {negative, zero, overflow, carry_out};

	always #20 clk = ~clk;

	task automatic check(input string name, input logic [DATA_WIDTH-1:0] expected, actual);
		if (expected !== actual) begin
			$display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
			$display("TEST FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("TEST FAILED");
		$fatal(1, "run aborted");
	endtask

	task automatic add_row(input string name, input logic [DATA_WIDTH-1:0] rd1, rd2, imm_v,
			input logic src, input alu_op_t op, input logic sf,
			input logic [DATA_WIDTH-1:0] pc_v, off, input br_kind_t kind, input cond_t cnd,
			input logic [DATA_WIDTH-1:0] e_res, e_store, e_target,
			input logic e_taken, input logic [3:0] e_nzvc);
		t_name[n_rows]   = name;
		t_issue[n_rows]  = 1'b1;
		t_rd1[n_rows]    = rd1;
		t_rd2[n_rows]    = rd2;
		t_imm[n_rows]    = imm_v;
		t_src[n_rows]    = src;
		t_op[n_rows]     = op;
		t_sf[n_rows]     = sf;
		t_pc[n_rows]     = pc_v;
		t_off[n_rows]    = off;
		t_kind[n_rows]   = kind;
		t_cond[n_rows]   = cnd;
		x_res[n_rows]    = e_res;
		x_store[n_rows]  = e_store;
		x_target[n_rows] = e_target;
		x_taken[n_rows]  = e_taken;
		x_nzvc[n_rows]   = e_nzvc;
		n_rows++;
	endtask

	// a cycle with issue low that offers a payload the DUT must ignore
	task automatic add_gap(input string name);
		t_name[n_rows]  = name;
		t_issue[n_rows] = 1'b0;
		t_rd1[n_rows]   = 64'h1111;
		t_rd2[n_rows]   = 64'h2222;
		t_imm[n_rows]   = 64'h3333;
		t_src[n_rows]   = 1'b1;
		t_op[n_rows]    = ALU_ADD;
		t_sf[n_rows]    = 1'b1;
		t_pc[n_rows]    = 64'h4444;
		t_off[n_rows]   = 64'h1;
		t_kind[n_rows]  = BR_UNCOND;
		t_cond[n_rows]  = COND_AL;
		n_rows++;
	endtask

	`include "ex_tb_vectors.svh"

	// watchdog sized by the reset length and one cycle per row plus slack
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= limit) begin
			if (pending.size() != 0)
				abort_run($sformatf("timeout: %0d issued instructions never gave result_valid",
					pending.size()));
			else
				abort_run("timeout: the run did not reach its end");
		end
	end

	// outputs are settled at the falling edge
	always @(negedge clk) begin
		int idx;
		if (!reset) begin
			if (result_valid) begin
				if (pending.size() == 0) begin
					abort_run("result_valid rose with no instruction outstanding");
				end else begin
					idx = pending.pop_front();
					check({t_name[idx], " result"}, x_res[idx], alu_result);
					check({t_name[idx], " store_data"}, x_store[idx], store_data);
					check({t_name[idx], " br_target"}, x_target[idx], br_target);
					check({t_name[idx], " br_taken"}, DATA_WIDTH'(x_taken[idx]),
						DATA_WIDTH'(br_taken));
					check({t_name[idx], " flags"}, DATA_WIDTH'(x_nzvc[idx]), DATA_WIDTH'(nzvc));
					last_res    = alu_result;
					last_store  = store_data;
					last_target = br_target;
					last_nzvc   = nzvc;
					seen_result = 1'b1;
				end
			end else begin
				// with nothing retiring there is no taken pulse and flags and data hold
				check("idle br_taken", '0, DATA_WIDTH'(br_taken));
				check("idle flags", DATA_WIDTH'(last_nzvc), DATA_WIDTH'(nzvc));
				if (seen_result) begin
					check("idle result", last_res, alu_result);
					check("idle store_data", last_store, store_data);
					check("idle br_target", last_target, br_target);
				end
			end
		end
	end

	initial begin
		reset      = 1'b1;
		issue      = 1'b0;
		read_data1 = '0;
		read_data2 = '0;
		pc         = '0;
		imm        = '0;
		br_offset  = '0;
		alu_op     = ALU_PASS_B;
		alu_src    = 1'b0;
		set_flags  = 1'b0;
		br_kind    = BR_NONE;
		cond       = COND_EQ;
		load_table();
		limit = RESET_CYCLES + n_rows + 20;
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;
		// a few idle cycles so the post-reset state gets checked
		repeat (3) @(posedge clk);
		for (int i = 0; i < n_rows; i++) begin
			issue      <= t_issue[i];
			read_data1 <= t_rd1[i];
			read_data2 <= t_rd2[i];
			imm        <= t_imm[i];
			alu_src    <= t_src[i];
			alu_op     <= t_op[i];
			set_flags  <= t_sf[i];
			pc         <= t_pc[i];
			br_offset  <= t_off[i];
			br_kind    <= t_kind[i];
			cond       <= t_cond[i];
			if (t_issue[i])
				pending.push_back(i);
			@(posedge clk);
		end
		issue <= 1'b0;
		// drain the outstanding results under the watchdog
		while (pending.size() != 0)
			@(posedge clk);
		repeat (2) @(posedge clk);
		$display("TEST PASSED");
		$finish;
	end

endmodule

// File: project.f
+incdir+tests
rtl/ex_pkg.sv
rtl/ex_operand_stage.sv
rtl/ex_alu.sv
rtl/ex_branch_unit.sv
rtl/ex_result_stage.sv
rtl/ex_top.sv
tests/ex_tb.sv

// File: run.sh
#!/bin/sh
# Builds the execute stage testbench with Verilator and runs it.
# Exits non-zero unless the simulation prints its pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module ex_tb -f project.f -o ex_tb_sim
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

output=$(./obj_dir/ex_tb_sim 2>&1)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -q '^TEST PASSED$'; then
	exit 0
fi
echo "pass line not found in simulation output"
exit 1
